// ==== all.f ====
+incdir+source
source/vertex_job_pkg.sv
source/vertex_job_ifs.sv
source/vertex_job_regs.sv
source/vertex_read_requester.sv
source/vertex_line_unpacker.sv
source/vertex_job_assembler.sv
source/vertex_job_fifo.sv
source/vertex_job_control.sv
tb/tb_vertex_job_control.sv

// ==== Makefile ====
# Verilator build and run for the vertex job controller

VERILATOR ?= verilator
TOP       ?= tb_vertex_job_control
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# the simulator exits with a failing status on any error
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_vertex_job_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_cfg.svh"

module tb_vertex_job_control import vertex_job_pkg::*; ();

	localparam int ROWS        = 6;
	localparam int HOLD_CYCLES = 300; // job_pop withheld this long in hold rows
	localparam int ALFULL_HOLD = 30;  // cmd_alfull solid high after each start
	localparam int DRAIN_LIMIT = 20;
	localparam logic [31:0] SEED = 32'hdd3c_8e63;

	logic                            clock;
	logic                            rstn;
	logic                            start;
	vertex_count_t                   num_vertices;
	logic [`VJ_ADDR_WIDTH-1:0]       in_degree_base;
	logic [`VJ_ADDR_WIDTH-1:0]       out_degree_base;
	logic [`VJ_ADDR_WIDTH-1:0]       edges_idx_base;
	logic                            cmd_alfull;
	logic                            cmd_valid;
	logic [`VJ_ADDR_WIDTH-1:0]       cmd_address;
	logic [11:0]                     cmd_size;
	array_tag_t                      cmd_array;
	vertex_count_t                   cmd_count;
	logic                            rsp_valid;
	array_tag_t                      rsp_array;
	vertex_count_t                   rsp_count;
	logic [$bits(cacheline_t)-1:0]   rsp_line;
	logic                            job_pop;
	logic                            job_valid;
	vertex_t                         job_id;
	vertex_t                         job_in_degree;
	vertex_t                         job_out_degree;
	vertex_t                         job_edges_idx;
	vertex_count_t                   filtered_count;

////////////////////////////////////////////////////////////////////////////
// stimulus table
// vertices, three bases, cmd_alfull pattern, job_pop hold, expected batches
////////////////////////////////////////////////////////////////////////////
	vertex_count_t row_vertices [ROWS] = '{32'd1, 32'd4, 32'd7, 32'd10, 32'd40, 32'd10};
	logic [`VJ_ADDR_WIDTH-1:0] row_in_base [ROWS] = '{
		64'h0000_0000_0000_1000, 64'h0000_0000_0004_0000, 64'h0000_0001_0000_0000,
		64'h0000_0000_0010_0040, 64'h0000_0000_0800_0000, 64'h0000_00a0_0000_0100};
	logic [`VJ_ADDR_WIDTH-1:0] row_out_base [ROWS] = '{
		64'h0000_0000_0000_2000, 64'h0000_0000_0005_0000, 64'h0000_0002_0000_0000,
		64'h0000_0000_0020_0080, 64'h0000_0000_0900_0000, 64'h0000_00b0_0000_0200};
	logic [`VJ_ADDR_WIDTH-1:0] row_edges_base [ROWS] = '{
		64'h0000_0000_0000_3000, 64'h0000_0000_0006_0000, 64'h0000_0003_0000_0000,
		64'h0000_0000_0030_00c0, 64'h0000_0000_0a00_0000, 64'h0000_00c0_0000_0300};
	logic row_alfull [ROWS]  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
	logic row_hold [ROWS]    = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
	int   row_batches [ROWS] = '{1, 1, 2, 3, 10, 3};

	logic [31:0]               lfsr = SEED;
	int                        cycle_count;
	int                        cmd_index;   // commands seen in this row
	int                        batch_total;
	int                        alfull_until;
	logic                      alfull_mode;
	logic                      pop_enable;
	vertex_count_t             cur_vertices;
	logic [`VJ_ADDR_WIDTH-1:0] cur_base [3]; // indexed by array tag
	vertex_count_t             expected_filtered;
	vertex_job_t               expected_jobs [$];
	array_tag_t                rsp_tag_q [$]; // memory model's pending responses
	logic [`VJ_ADDR_WIDTH-1:0] rsp_addr_q [$];
	vertex_count_t             rsp_count_q [$];
	int                        rsp_due_q [$];

	vertex_job_control vertex_job_control_inst (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.in_degree_base  (in_degree_base),
		.out_degree_base (out_degree_base),
		.edges_idx_base  (edges_idx_base),
		.cmd_alfull      (cmd_alfull),
		.cmd_valid       (cmd_valid),
		.cmd_address     (cmd_address),
		.cmd_size        (cmd_size),
		.cmd_array       (cmd_array),
		.cmd_count       (cmd_count),
		.rsp_valid       (rsp_valid),
		.rsp_array       (rsp_array),
		.rsp_count       (rsp_count),
		.rsp_line        (rsp_line),
		.job_pop         (job_pop),
		.job_valid       (job_valid),
		.job_id          (job_id),
		.job_in_degree   (job_in_degree),
		.job_out_degree  (job_out_degree),
		.job_edges_idx   (job_edges_idx),
		.filtered_count  (filtered_count)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// any address gives a word and about one out_degree word in four is zero
	function automatic vertex_t memory_word(input array_tag_t tag,
			input logic [`VJ_ADDR_WIDTH-1:0] address);
		logic [31:0] state;
		logic [33:0] word_bits;
		state     = SEED ^ address[31:0] ^ address[63:32];
		word_bits = '0;
		if (state == '0)
			state = SEED;
		for (int i = 0; i < 34; i++) begin
			state     = lfsr_step(state);
			word_bits = {word_bits[32:0], state[0]};
		end
		if (tag == OUT_DEGREE && word_bits[33:32] == 2'b00)
			return '0;
		return word_bits[31:0];
	endfunction

	task automatic print_failure(input string text);
		$display("%s", text);
		$display("RESULT: FAIL");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		assert (actual === expected) else begin
			print_failure($sformatf("Error: %s is %h, expected %h", name, actual, expected));
			$fatal(1);
		end
	endtask

	task automatic load_row(input int r);
		vertex_job_t job;
		cur_vertices      = row_vertices[r];
		cur_base[0]       = row_in_base[r];
		cur_base[1]       = row_out_base[r];
		cur_base[2]       = row_edges_base[r];
		batch_total       = row_batches[r];
		cmd_index         = 0;
		alfull_mode       = row_alfull[r];
		alfull_until      = cycle_count + ALFULL_HOLD;
		expected_filtered = '0;
		expected_jobs.delete();
		for (int v = 0; v < int'(cur_vertices); v++) begin
			job[JOB_ID]         = vertex_t'(v);
			job[JOB_IN_DEGREE]  = memory_word(IN_DEGREE, cur_base[0] + 64'(4 * v));
			job[JOB_OUT_DEGREE] = memory_word(OUT_DEGREE, cur_base[1] + 64'(4 * v));
			job[JOB_EDGES_IDX]  = memory_word(EDGES_IDX, cur_base[2] + 64'(4 * v));
			if (job[JOB_OUT_DEGREE] != '0)
				expected_jobs.push_back(job);
			else
				expected_filtered = expected_filtered + 1; // dropped by the filter
		end
	endtask

	task automatic check_command();
		int            batch;
		int            which;
		vertex_count_t left;
		vertex_count_t exp_count;
		assert (cmd_index < 3 * batch_total) else begin
			print_failure("a read command came after the last batch of the row");
			$fatal(1);
		end
		assert (!cmd_alfull) else begin
			print_failure("a read command followed a cycle with cmd_alfull high");
			$fatal(1);
		end
		batch     = cmd_index / 3;
		which     = cmd_index % 3; // in_degree, out_degree, edges_idx
		left      = cur_vertices - vertex_count_t'(batch * `VJ_LINE_VERTICES);
		exp_count = (left < vertex_count_t'(`VJ_LINE_VERTICES)) ?
			left : vertex_count_t'(`VJ_LINE_VERTICES);
		check_value("cmd_array", 64'(cmd_array), 64'(which));
		check_value("cmd_address", cmd_address,
			cur_base[which] + 64'(batch * `VJ_LINE_BYTES));
		check_value("cmd_size", 64'(cmd_size), 64'(`VJ_LINE_BYTES));
		check_value("cmd_count", 64'(cmd_count), 64'(exp_count));
		rsp_tag_q.push_back(cmd_array);
		rsp_addr_q.push_back(cmd_address);
		rsp_count_q.push_back(cmd_count);
		rsp_due_q.push_back(cycle_count + 1 + int'(take_bits(3)));
		cmd_index++;
	endtask

////////////////////////////////////////////////////////////////////////////
// one clock cycle that samples on the falling edge and then drives
////////////////////////////////////////////////////////////////////////////
	task automatic step();
		logic [31:0] roll;
		logic [31:0] pop_roll;
		int          slot;
		cacheline_t  line;
		vertex_job_t head;
		@(negedge clock);
		cycle_count++;
		if (cmd_valid)
			check_command();
		roll     = take_bits(2);
		pop_roll = take_bits(2);
		if (pop_enable && job_valid && pop_roll[1:0] != 2'b00) begin
			assert (expected_jobs.size() != 0) else begin
				print_failure("a job came out of the FIFO that was not expected");
				$fatal(1);
			end
			head = expected_jobs.pop_front();
			check_value("job_id", 64'(job_id), 64'(head[JOB_ID]));
			check_value("job_in_degree", 64'(job_in_degree), 64'(head[JOB_IN_DEGREE]));
			check_value("job_out_degree", 64'(job_out_degree), 64'(head[JOB_OUT_DEGREE]));
			check_value("job_edges_idx", 64'(job_edges_idx), 64'(head[JOB_EDGES_IDX]));
			job_pop = 1'b1;
		end else begin
			job_pop = 1'b0;
		end
		cmd_alfull = alfull_mode && (cycle_count < alfull_until || roll[1:0] != 2'b00);
		slot = -1;
		foreach (rsp_due_q[i])
			if (slot < 0 && rsp_due_q[i] <= cycle_count)
				slot = i; // first due response goes out
		if (slot >= 0) begin
			for (int i = 0; i < `VJ_LINE_VERTICES; i++)
				line.words[i] = memory_word(rsp_tag_q[slot], rsp_addr_q[slot] + 64'(4 * i));
			rsp_valid = 1'b1;
			rsp_array = rsp_tag_q[slot];
			rsp_count = rsp_count_q[slot];
			rsp_line  = line.flat;
			rsp_tag_q.delete(slot);
			rsp_addr_q.delete(slot);
			rsp_count_q.delete(slot);
			rsp_due_q.delete(slot);
		end else begin
			rsp_valid = 1'b0;
			rsp_line  = '0;
		end
	endtask

	initial begin
		int row_cycles;
		int drain;
		start           = 1'b0;
		num_vertices    = '0;
		in_degree_base  = '0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		cmd_alfull      = 1'b0;
		rsp_valid       = 1'b0;
		rsp_array       = IN_DEGREE;
		rsp_count       = '0;
		rsp_line        = '0;
		job_pop         = 1'b0;
		rstn            = 1'b0;
		cycle_count     = 0;
		cmd_index       = 0;
		batch_total     = 0;
		alfull_mode     = 1'b0;
		pop_enable      = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// idle until the first start
		repeat (10) begin
			step();
			check_value("cmd_valid", 64'(cmd_valid), 64'(0));
			check_value("job_valid", 64'(job_valid), 64'(0));
			check_value("filtered_count", 64'(filtered_count), 64'(0));
		end

		for (int r = 0; r < ROWS; r++) begin
			load_row(r);
			pop_enable      = !row_hold[r];
			num_vertices    = row_vertices[r];
			in_degree_base  = row_in_base[r];
			out_degree_base = row_out_base[r];
			edges_idx_base  = row_edges_base[r];
			start           = 1'b1;
			step();
			start      = 1'b0;
			row_cycles = 0;
			while (!pop_enable || cmd_index != 3 * batch_total || rsp_due_q.size() != 0 ||
					expected_jobs.size() != 0) begin
				step();
				row_cycles++;
				if (!pop_enable && row_cycles == HOLD_CYCLES) begin
					if (expected_jobs.size() != 0)
						check_value("job_valid", 64'(job_valid), 64'(1));
					// the requester stalls when more jobs are kept than the FIFO takes
					if (expected_jobs.size() > `VJ_FIFO_DEPTH - `VJ_LINE_VERTICES)
						assert (cmd_index < 3 * batch_total) else begin
							print_failure("commands kept going while job_pop was withheld");
							$fatal(1);
						end
					pop_enable = 1'b1;
				end
			end
			drain = 0;
			while (filtered_count != expected_filtered && drain < DRAIN_LIMIT) begin
				step();
				drain++;
			end
			check_value("filtered_count", 64'(filtered_count), 64'(expected_filtered));
			repeat (4) step();
			check_value("job_valid", 64'(job_valid), 64'(0));
		end
		$display("RESULT: PASS");
		$finish;
	end

	// watchdog budget scales with the table
	initial begin
		int limit;
		limit = 200;
		for (int r = 0; r < ROWS; r++)
			limit = limit + 400 * int'(row_vertices[r]);
		repeat (limit) @(posedge clock);
		print_failure("timeout: the run did not finish within the cycle budget");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== source/vertex_job_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_cfg.svh"

module vertex_job_control import vertex_job_pkg::*; (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  start,
	input  vertex_count_t                         num_vertices,
	input  logic [`VJ_ADDR_WIDTH-1:0]             in_degree_base,
	input  logic [`VJ_ADDR_WIDTH-1:0]             out_degree_base,
	input  logic [`VJ_ADDR_WIDTH-1:0]             edges_idx_base,
	input  logic                                  cmd_alfull,
	output logic                                  cmd_valid,
	output logic [`VJ_ADDR_WIDTH-1:0]             cmd_address,
	output logic [11:0]                           cmd_size,
	output array_tag_t                            cmd_array,
	output vertex_count_t                         cmd_count,
	input  logic                                  rsp_valid,
	input  array_tag_t                            rsp_array,
	input  vertex_count_t                         rsp_count,
	input  logic [$bits(cacheline_t)-1:0]         rsp_line,
	input  logic                                  job_pop,
	output logic                                  job_valid,
	output vertex_t                               job_id,
	output vertex_t                               job_in_degree,
	output vertex_t                               job_out_degree,
	output vertex_t                               job_edges_idx,
	output vertex_count_t                         filtered_count
);

	logic                            batch_room;
	logic                            push;
	vertex_job_t                     push_job;
	logic [$clog2(`VJ_FIFO_DEPTH):0] fifo_count;
	logic                            fifo_alfull;

	job_desc_if      desc_if ();
	vertex_stream_if in_deg_if ();
	vertex_stream_if out_deg_if ();
	vertex_stream_if edges_if ();

	vertex_job_regs vertex_job_regs_inst (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.in_degree_base  (in_degree_base),
		.out_degree_base (out_degree_base),
		.edges_idx_base  (edges_idx_base),
		.desc            (desc_if.source)
	);

	vertex_read_requester vertex_read_requester_inst (
		.clock       (clock),
		.rstn        (rstn),
		.cmd_alfull  (cmd_alfull),
		.rsp_valid   (rsp_valid),
		.batch_room  (batch_room),
		.cmd_valid   (cmd_valid),
		.cmd_address (cmd_address),
		.cmd_size    (cmd_size),
		.cmd_array   (cmd_array),
		.cmd_count   (cmd_count),
		.desc        (desc_if.sink)
	);

////////////////////////////////////////////////////////////////////////////
// one unpacker per array
////////////////////////////////////////////////////////////////////////////
	vertex_line_unpacker #(.array(IN_DEGREE)) in_degree_unpacker_inst (
		.clock     (clock),
		.rstn      (rstn),
		.rsp_valid (rsp_valid),
		.rsp_array (rsp_array),
		.rsp_count (rsp_count),
		.rsp_line  (rsp_line),
		.stream    (in_deg_if.source)
	);

	vertex_line_unpacker #(.array(OUT_DEGREE)) out_degree_unpacker_inst (
		.clock     (clock),
		.rstn      (rstn),
		.rsp_valid (rsp_valid),
		.rsp_array (rsp_array),
		.rsp_count (rsp_count),
		.rsp_line  (rsp_line),
		.stream    (out_deg_if.source)
	);

	vertex_line_unpacker #(.array(EDGES_IDX)) edges_idx_unpacker_inst (
		.clock     (clock),
		.rstn      (rstn),
		.rsp_valid (rsp_valid),
		.rsp_array (rsp_array),
		.rsp_count (rsp_count),
		.rsp_line  (rsp_line),
		.stream    (edges_if.source)
	);

	vertex_job_assembler vertex_job_assembler_inst (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.fifo_count     (fifo_count),
		.fifo_alfull    (fifo_alfull),
		.push           (push),
		.push_job       (push_job),
		.batch_room     (batch_room),
		.filtered_count (filtered_count),
		.in_deg         (in_deg_if.sink),
		.out_deg        (out_deg_if.sink),
		.edges          (edges_if.sink)
	);

	// job words split out by index with the id lowest
	vertex_job_fifo vertex_job_fifo_inst (
		.clock    (clock),
		.rstn     (rstn),
		.push     (push),
		.push_job (push_job),
		.pop      (job_pop),
		.job      ({job_edges_idx, job_out_degree, job_in_degree, job_id}),
		.valid    (job_valid),
		.count    (fifo_count),
		.alfull   (fifo_alfull)
	);

endmodule

`default_nettype wire

// ==== source/vertex_job_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_cfg.svh"

module vertex_job_fifo import vertex_job_pkg::*; (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              push,
	input  vertex_job_t                       push_job,
	input  logic                              pop,
	output vertex_job_t                       job,
	output logic                              valid,
	output logic [$clog2(`VJ_FIFO_DEPTH):0] count,
	output logic                              alfull
);

	localparam int PTR_W = $clog2(`VJ_FIFO_DEPTH);
	localparam logic [PTR_W:0] DEPTH        = `VJ_FIFO_DEPTH;
	localparam logic [PTR_W:0] ALFULL_LEVEL = `VJ_FIFO_DEPTH - 2;

	vertex_job_t      mem [`VJ_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr; // wraps on its own at the power-of-two depth
	logic [PTR_W-1:0] rd_ptr;
	logic             full;
	logic             wr_en;
	logic             rd_en;

	assign full   = (count == DEPTH);
	assign valid  = (count != '0);
	assign alfull = (count >= ALFULL_LEVEL);
	assign wr_en  = push && !full;
	assign rd_en  = pop && valid;
	assign job    = mem[rd_ptr]; // head shows without a pop

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en)
			mem[wr_ptr] <= push_job;
	end

	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	no_pop_when_empty: assert property (@(posedge clock) disable iff (!rstn) pop |-> valid);

endmodule

`default_nettype wire

// ==== source/vertex_job_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_cfg.svh"

module vertex_job_assembler import vertex_job_pkg::*; (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              start,
	input  logic [$clog2(`VJ_FIFO_DEPTH):0] fifo_count,
	input  logic                              fifo_alfull,
	output logic                              push,
	output vertex_job_t                       push_job,
	output logic                              batch_room,
	output vertex_count_t                     filtered_count,
	vertex_stream_if.sink                     in_deg,
	vertex_stream_if.sink                     out_deg,
	vertex_stream_if.sink                     edges
);

	// room for two more lines before a new batch
	localparam logic [$clog2(`VJ_FIFO_DEPTH):0] ROOM_LIMIT =
		`VJ_FIFO_DEPTH - 2 * `VJ_LINE_VERTICES;

	vertex_count_t next_id;
	logic          all_pending;
	logic          any_pending;
	logic          shift;
	logic          keep; // vertex has outgoing edges

	assign all_pending = in_deg.pending && out_deg.pending && edges.pending;
	assign any_pending = in_deg.pending || out_deg.pending || edges.pending;
	assign shift       = all_pending && !fifo_alfull; // stall on a filling FIFO
	assign batch_room  = !any_pending && (fifo_count <= ROOM_LIMIT);
	assign keep        = (out_deg.vertex != '0);

	assign in_deg.shift  = shift;
	assign out_deg.shift = shift;
	assign edges.shift   = shift;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push           <= 1'b0;
			next_id        <= '0;
			filtered_count <= '0;
		end else begin
			push <= in_deg.valid && keep;
			if (start) begin
				next_id        <= '0; // new descriptor numbers from zero
				filtered_count <= '0;
			end else if (in_deg.valid) begin
				next_id <= next_id + 1'b1;
				if (!keep)
					filtered_count <= filtered_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (in_deg.valid) begin
			push_job[JOB_ID]         <= next_id;
			push_job[JOB_IN_DEGREE]  <= in_deg.vertex;
			push_job[JOB_OUT_DEGREE] <= out_deg.vertex;
			push_job[JOB_EDGES_IDX]  <= edges.vertex;
		end
	end

	streams_in_step: assert property (@(posedge clock) disable iff (!rstn)
		(in_deg.valid == out_deg.valid) && (in_deg.valid == edges.valid));

endmodule

`default_nettype wire

// ==== source/vertex_line_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_line_unpacker import vertex_job_pkg::*; #(
	parameter array_tag_t array = IN_DEGREE
) (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          rsp_valid,
	input  array_tag_t                    rsp_array,
	input  vertex_count_t                 rsp_count,
	input  logic [$bits(cacheline_t)-1:0] rsp_line,
	vertex_stream_if.source               stream
);

	cacheline_t    line;
	vertex_count_t left; // words still to hand out
	logic          capture;
	logic          take;

	assign capture        = rsp_valid && (rsp_array == array);
	assign take           = stream.shift && (left != '0);
	assign stream.pending = (left != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			left         <= '0;
			stream.valid <= 1'b0;
		end else begin
			if (capture)
				left <= rsp_count;
			else if (take)
				left <= left - 1'b1;
			stream.valid <= take;
		end
	end

	// word 0 goes out first, then the line moves down one word
	always_ff @(posedge clock) begin
		if (capture)
			line.flat <= rsp_line;
		else if (take)
			line.flat <= line.flat >> $bits(vertex_t);
		if (take)
			stream.vertex <= line.words[0];
	end

	// the requester holds the next batch until this line is used up
	no_overlapping_line: assert property (@(posedge clock) disable iff (!rstn)
		capture |-> !stream.pending);

endmodule

`default_nettype wire

// ==== source/vertex_read_requester.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_cfg.svh"

module vertex_read_requester import vertex_job_pkg::*; (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      cmd_alfull,
	input  logic                      rsp_valid,
	input  logic                      batch_room,
	output logic                      cmd_valid,
	output logic [`VJ_ADDR_WIDTH-1:0] cmd_address,
	output logic [11:0]               cmd_size,
	output array_tag_t                cmd_array,
	output vertex_count_t             cmd_count,
	job_desc_if.sink                  desc
);

	localparam logic [2:0] ST_WAIT       = 3'd0;
	localparam logic [2:0] ST_SIZE       = 3'd1;
	localparam logic [2:0] ST_IN_DEGREE  = 3'd2;
	localparam logic [2:0] ST_OUT_DEGREE = 3'd3;
	localparam logic [2:0] ST_EDGES_IDX  = 3'd4;

	localparam logic [`VJ_ADDR_WIDTH-1:0] LINE_STEP = `VJ_LINE_BYTES;

	logic [2:0]                       state;
	vertex_count_t                    remaining;   // vertices not yet requested
	logic [`VJ_ADDR_WIDTH-1:0]        line_offset; // batch number times line bytes
	logic [`VJ_OUTSTANDING_WIDTH-1:0] outstanding;
	vertex_count_t                    batch_count;
	logic                             batch_go;
	logic                             send_ok;

	assign batch_count = (remaining > `VJ_LINE_VERTICES) ?
		vertex_count_t'(`VJ_LINE_VERTICES) : remaining;
	assign batch_go = desc.valid && (remaining != '0) && (outstanding == '0) &&
		!cmd_valid && batch_room;
	assign send_ok  = !cmd_alfull && !cmd_valid; // spaced pulses that honour back-pressure
	assign cmd_size = 12'(`VJ_LINE_BYTES);

////////////////////////////////////////////////////////////////////////////
// batch sequencing
////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= ST_WAIT;
			remaining   <= '0;
			line_offset <= '0;
			cmd_valid   <= 1'b0;
		end else if (desc.load) begin
			state       <= ST_WAIT;
			remaining   <= desc.num_vertices;
			line_offset <= '0;
			cmd_valid   <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;
			case (state)
				ST_WAIT: begin
					if (batch_go)
						state <= ST_SIZE;
				end
				ST_SIZE: begin
					remaining <= remaining - batch_count;
					state     <= ST_IN_DEGREE;
				end
				ST_IN_DEGREE: begin
					if (send_ok) begin
						cmd_valid <= 1'b1;
						state     <= ST_OUT_DEGREE;
					end
				end
				ST_OUT_DEGREE: begin
					if (send_ok) begin
						cmd_valid <= 1'b1;
						state     <= ST_EDGES_IDX;
					end
				end
				ST_EDGES_IDX: begin
					if (send_ok) begin
						cmd_valid   <= 1'b1;
						line_offset <= line_offset + LINE_STEP; // next line
						state       <= ST_WAIT;
					end
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	// command fields settle while cmd_valid is low
	always_ff @(posedge clock) begin
		case (state)
			ST_SIZE: cmd_count <= batch_count;
			ST_IN_DEGREE: begin
				cmd_address <= desc.in_degree_base + line_offset;
				cmd_array   <= IN_DEGREE;
			end
			ST_OUT_DEGREE: begin
				cmd_address <= desc.out_degree_base + line_offset;
				cmd_array   <= OUT_DEGREE;
			end
			ST_EDGES_IDX: begin
				cmd_address <= desc.edges_idx_base + line_offset;
				cmd_array   <= EDGES_IDX;
			end
			default: begin
			end
		endcase
	end

////////////////////////////////////////////////////////////////////////////
// response tracking
////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else if (cmd_valid && !rsp_valid)
			outstanding <= outstanding + 1'b1;
		else if (rsp_valid && !cmd_valid)
			outstanding <= outstanding - 1'b1;
	end

	outstanding_no_underflow: assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid && !cmd_valid |-> outstanding != '0);

	cmd_valid_spaced: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |=> !cmd_valid);

endmodule

`default_nettype wire

// ==== source/vertex_job_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_cfg.svh"

module vertex_job_regs import vertex_job_pkg::*; (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      start,
	input  vertex_count_t             num_vertices,
	input  logic [`VJ_ADDR_WIDTH-1:0] in_degree_base,
	input  logic [`VJ_ADDR_WIDTH-1:0] out_degree_base,
	input  logic [`VJ_ADDR_WIDTH-1:0] edges_idx_base,
	job_desc_if.source                desc
);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			desc.valid <= 1'b0;
			desc.load  <= 1'b0;
		end else begin
			desc.load <= start; // lines up with the new fields
			if (start)
				desc.valid <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			desc.num_vertices    <= num_vertices;
			desc.in_degree_base  <= in_degree_base;
			desc.out_degree_base <= out_degree_base;
			desc.edges_idx_base  <= edges_idx_base;
		end
	end

endmodule

`default_nettype wire

// ==== source/vertex_job_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vertex_job_cfg.svh"

// descriptor from the register block to the read requester
interface job_desc_if import vertex_job_pkg::*; ();
	logic                      valid; // a descriptor has been loaded
	logic                      load;  // one cycle with each new descriptor
	vertex_count_t             num_vertices;
	logic [`VJ_ADDR_WIDTH-1:0] in_degree_base;
	logic [`VJ_ADDR_WIDTH-1:0] out_degree_base;
	logic [`VJ_ADDR_WIDTH-1:0] edges_idx_base;

	modport source (
		output valid, load, num_vertices, in_degree_base, out_degree_base, edges_idx_base
	);
	modport sink (
		input valid, load, num_vertices, in_degree_base, out_degree_base, edges_idx_base
	);
endinterface

// one array's vertex words, unpacker to assembler
interface vertex_stream_if import vertex_job_pkg::*; ();
	logic    shift;   // take the next word
	logic    pending; // captured line not used up yet
	logic    valid;   // pulse one cycle after shift
	vertex_t vertex;

	modport source (
		input  shift,
		output pending, valid, vertex
	);
	modport sink (
		output shift,
		input  pending, valid, vertex
	);
endinterface

`default_nettype wire

// ==== source/vertex_job_pkg.sv ====
`default_nettype none

package vertex_job_pkg;

`include "vertex_job_cfg.svh"

	typedef logic [`VJ_VERTEX_WIDTH-1:0] vertex_t;
	typedef logic [31:0] vertex_count_t; // counts and ids

	typedef enum logic [1:0] {
		IN_DEGREE  = 2'd0,
		OUT_DEGREE = 2'd1,
		EDGES_IDX  = 2'd2
	} array_tag_t;

	// response data lands as a flat vector and the unpacker reads it by word
	// word 0 sits at the low end of the line
	typedef union packed {
		logic [`VJ_LINE_VERTICES*`VJ_VERTEX_WIDTH-1:0] flat;
		vertex_t [`VJ_LINE_VERTICES-1:0]               words;
	} cacheline_t;

	// one job is four words indexed by the constants below
	typedef vertex_t [3:0] vertex_job_t;

	localparam int JOB_ID         = 0;
	localparam int JOB_IN_DEGREE  = 1;
	localparam int JOB_OUT_DEGREE = 2;
	localparam int JOB_EDGES_IDX  = 3;

endpackage

`default_nettype wire

// ==== source/vertex_job_cfg.svh ====
`ifndef VERTEX_JOB_CFG_SVH
`define VERTEX_JOB_CFG_SVH

// vertex word and byte address widths
`define VJ_VERTEX_WIDTH 32
`define VJ_ADDR_WIDTH 64

// one cacheline holds four vertex words
`define VJ_LINE_VERTICES 4
`define VJ_LINE_BYTES 16 // also the batch address step and command size

// job buffer
`define VJ_FIFO_DEPTH 16

// outstanding read responses
`define VJ_OUTSTANDING_WIDTH 4

`endif
